/* logic/uart_pkg.sv */
package uart_pkg;

  // oversample ticks per serial bit.
  localparam int OVERSAMPLE = 16;

  // data bits per frame, framed by one start and one stop bit.
  localparam int DATA_BITS = 8;

  // one received byte, valid for a single cycle.
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_stream_t;

endpackage

/* logic/thermo_pkg.sv */
package thermo_pkg;

  // encoding follows the low nibble of the ascii letters 'A' to 'I'.
  typedef enum logic [3:0] {
    TH_NONE       = 4'd0,
    TH_SOLAR      = 4'd1,
    TH_SOLAR_COOL = 4'd2,
    TH_SOLAR_HEAT = 4'd3,
    TH_GREEN_COOL = 4'd4,
    TH_GREEN_HEAT = 4'd5,
    TH_AMB_COOL   = 4'd6,
    TH_AMB_HEAT   = 4'd7,
    TH_GEO_COOL   = 4'd8,
    TH_GEO_HEAT   = 4'd9
  } th_id_e;

  typedef struct packed {
    logic [15:0] solar;
    logic [7:0]  solar_cooldown;
    logic [7:0]  solar_heatup;
    logic [7:0]  greenhouse_cooldown;
    logic [7:0]  greenhouse_heatup;
    logic [7:0]  ambient_cooldown;
    logic [7:0]  ambient_heatup;
    logic [7:0]  geothermal_cooldown;
    logic [7:0]  geothermal_heatup;
  } thresholds_t;

  typedef struct packed {
    logic   valid;
    th_id_e id;
    logic   up;
  } th_cmd_t;

  // whole value, or the two bytes sent back on tx.
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } th_word_u;

  localparam thresholds_t RESET_THRESHOLDS = '{
    solar:               16'd1000,
    solar_cooldown:      8'd40,
    solar_heatup:        8'd30,
    greenhouse_cooldown: 8'd40,
    greenhouse_heatup:   8'd30,
    ambient_cooldown:    8'd40,
    ambient_heatup:      8'd30,
    geothermal_cooldown: 8'd40,
    geothermal_heatup:   8'd30
  };

  localparam logic [7:0] CMD_UP        = 8'h77;
  localparam logic [7:0] CMD_DOWN      = 8'h73;
  localparam logic [7:0] CMD_SEL_FIRST = 8'h41;
  localparam logic [7:0] CMD_SEL_LAST  = 8'h49;

endpackage

/* logic/baud_timer.sv */
`timescale 1ns/1ps

module baud_timer #(
  parameter int CLKS_PER_TICK = 4
) (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
  localparam logic [CW-1:0] RELOAD = CW'(CLKS_PER_TICK - 1);

  logic [CW-1:0] count;

  // one tick per reload period.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= RELOAD;
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= RELOAD;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   tick,
  input  logic                   rx,
  output uart_pkg::byte_stream_t rx_byte
);

  localparam int CW = $clog2(uart_pkg::OVERSAMPLE);
  localparam int BW = $clog2(uart_pkg::DATA_BITS);
  localparam logic [CW-1:0] MID_TICK  = CW'(uart_pkg::OVERSAMPLE / 2 - 1);
  localparam logic [CW-1:0] LAST_TICK = CW'(uart_pkg::OVERSAMPLE - 1);
  localparam logic [BW-1:0] LAST_BIT  = BW'(uart_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

  state_t                       state;
  logic [1:0]                   rx_sync;
  logic [CW-1:0]                tick_cnt;
  logic [BW-1:0]                bit_cnt;
  logic [uart_pkg::DATA_BITS-1:0] shift;
  logic                         valid;
  logic                         sample;

  // two-flop synchronizer, line idles high.
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  assign sample = tick && (tick_cnt == LAST_TICK);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      valid    <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          tick_cnt <= '0;
          if (!rx_sync[1]) begin
            state <= START;
          end
        end
        START: begin
          // confirm the start bit at mid-bit.
          if (tick && tick_cnt == MID_TICK) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync[1] ? IDLE : DATA;
          end
        end
        DATA: begin
          if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= STOP;
            end
          end
        end
        STOP: begin
          if (sample) begin
            valid <= rx_sync[1];
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // lsb arrives first.
  always_ff @(posedge clk) begin
    if (state == DATA && sample) begin
      shift <= {rx_sync[1], shift[uart_pkg::DATA_BITS-1:1]};
    end
  end

  assign rx_byte = '{valid: valid, data: shift};

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       tick,
  input  logic       tx_valid,
  input  logic [7:0] tx_data,
  output logic       tx_ready,
  output logic       tx
);

  localparam int CW = $clog2(uart_pkg::OVERSAMPLE);
  localparam int BW = $clog2(uart_pkg::DATA_BITS);
  localparam logic [CW-1:0] LAST_TICK = CW'(uart_pkg::OVERSAMPLE - 1);
  localparam logic [BW-1:0] LAST_BIT  = BW'(uart_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

  state_t        state;
  logic [CW-1:0] tick_cnt;
  logic [BW-1:0] bit_cnt;
  logic [7:0]    shift;
  logic          accept;
  logic          bit_end;

  assign tx_ready = (state == IDLE);
  assign accept   = tx_valid && tx_ready;
  assign bit_end  = tick && (tick_cnt == LAST_TICK);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (accept) begin
            state <= START;
          end
        end
        START: if (bit_end) state <= DATA;
        DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= STOP;
            end
          end
        end
        STOP: if (bit_end) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      shift <= tx_data;
    end else if (state == DATA && bit_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  // line level follows the frame position.
  assign tx = (state == START) ? 1'b0 :
              (state == DATA)  ? shift[0] : 1'b1;

endmodule

/* logic/command_fsm.sv */
`timescale 1ns/1ps

module command_fsm (
  input  logic                   clk,
  input  logic                   reset,
  input  uart_pkg::byte_stream_t rx_byte,
  input  thermo_pkg::thresholds_t thresholds,
  output thermo_pkg::th_cmd_t    th_cmd,
  output logic                   tx_valid,
  output logic [7:0]             tx_data,
  input  logic                   tx_ready
);

  typedef enum logic [1:0] {IDLE, UPDATE, ECHO_HI, ECHO_LO} state_t;

  state_t               state;
  thermo_pkg::th_id_e   sel;
  logic                 lo_taken;
  logic                 is_select;
  logic                 is_step;
  thermo_pkg::th_word_u echo_word;

  assign is_select = (rx_byte.data >= thermo_pkg::CMD_SEL_FIRST) &&
                     (rx_byte.data <= thermo_pkg::CMD_SEL_LAST);
  assign is_step   = ((rx_byte.data == thermo_pkg::CMD_UP) ||
                      (rx_byte.data == thermo_pkg::CMD_DOWN)) &&
                     (sel != thermo_pkg::TH_NONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      sel      <= thermo_pkg::TH_NONE;
      lo_taken <= 1'b0;
      th_cmd   <= '{valid: 1'b0, id: thermo_pkg::TH_NONE, up: 1'b0};
    end else begin
      th_cmd.valid <= 1'b0;
      case (state)
        IDLE: begin
          if (rx_byte.valid && is_select) begin
            // letter low nibble is the id.
            sel   <= thermo_pkg::th_id_e'(rx_byte.data[3:0]);
            state <= UPDATE;
          end else if (rx_byte.valid && is_step) begin
            th_cmd <= '{valid: 1'b1, id: sel, up: (rx_byte.data == thermo_pkg::CMD_UP)};
            state  <= UPDATE;
          end
        end
        UPDATE: state <= (sel == thermo_pkg::TH_SOLAR) ? ECHO_HI : ECHO_LO;
        ECHO_HI: if (tx_ready) state <= ECHO_LO;
        ECHO_LO: begin
          // hold until the last byte has left the line.
          if (tx_ready) begin
            lo_taken <= !lo_taken;
            if (lo_taken) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // bank has applied the update by the first echo cycle.
  always_comb begin
    case (sel)
      thermo_pkg::TH_SOLAR:      echo_word.word = thresholds.solar;
      thermo_pkg::TH_SOLAR_COOL: echo_word.word = {8'h00, thresholds.solar_cooldown};
      thermo_pkg::TH_SOLAR_HEAT: echo_word.word = {8'h00, thresholds.solar_heatup};
      thermo_pkg::TH_GREEN_COOL: echo_word.word = {8'h00, thresholds.greenhouse_cooldown};
      thermo_pkg::TH_GREEN_HEAT: echo_word.word = {8'h00, thresholds.greenhouse_heatup};
      thermo_pkg::TH_AMB_COOL:   echo_word.word = {8'h00, thresholds.ambient_cooldown};
      thermo_pkg::TH_AMB_HEAT:   echo_word.word = {8'h00, thresholds.ambient_heatup};
      thermo_pkg::TH_GEO_COOL:   echo_word.word = {8'h00, thresholds.geothermal_cooldown};
      thermo_pkg::TH_GEO_HEAT:   echo_word.word = {8'h00, thresholds.geothermal_heatup};
      default:                   echo_word.word = 16'h0000;
    endcase
  end

  assign tx_valid = (state == ECHO_HI) || ((state == ECHO_LO) && !lo_taken);
  assign tx_data  = (state == ECHO_HI) ? echo_word.bytes.hi : echo_word.bytes.lo;

endmodule

/* logic/threshold_bank.sv */
`timescale 1ns/1ps

module threshold_bank (
  input  logic                    clk,
  input  logic                    reset,
  input  thermo_pkg::th_cmd_t     th_cmd,
  output thermo_pkg::thresholds_t thresholds
);

  localparam logic [15:0] MAX16 = 16'hffff;
  localparam logic [15:0] MAX8  = 16'h00ff;

  thermo_pkg::thresholds_t th_next;

  // saturating step, stops at zero or at max_value.
  function automatic logic [15:0] step(input logic [15:0] value,
                                       input logic [15:0] max_value,
                                       input logic        up);
    logic [15:0] result;
    result = value;
    if (up && value != max_value) begin
      result = value + 16'd1;
    end else if (!up && value != 16'd0) begin
      result = value - 16'd1;
    end
    return result;
  endfunction

  always_comb begin
    th_next = thresholds;
    if (th_cmd.valid) begin
      case (th_cmd.id)
        thermo_pkg::TH_SOLAR:
          th_next.solar = step(thresholds.solar, MAX16, th_cmd.up);
        thermo_pkg::TH_SOLAR_COOL:
          th_next.solar_cooldown =
            8'(step({8'h00, thresholds.solar_cooldown}, MAX8, th_cmd.up));
        thermo_pkg::TH_SOLAR_HEAT:
          th_next.solar_heatup =
            8'(step({8'h00, thresholds.solar_heatup}, MAX8, th_cmd.up));
        thermo_pkg::TH_GREEN_COOL:
          th_next.greenhouse_cooldown =
            8'(step({8'h00, thresholds.greenhouse_cooldown}, MAX8, th_cmd.up));
        thermo_pkg::TH_GREEN_HEAT:
          th_next.greenhouse_heatup =
            8'(step({8'h00, thresholds.greenhouse_heatup}, MAX8, th_cmd.up));
        thermo_pkg::TH_AMB_COOL:
          th_next.ambient_cooldown =
            8'(step({8'h00, thresholds.ambient_cooldown}, MAX8, th_cmd.up));
        thermo_pkg::TH_AMB_HEAT:
          th_next.ambient_heatup =
            8'(step({8'h00, thresholds.ambient_heatup}, MAX8, th_cmd.up));
        thermo_pkg::TH_GEO_COOL:
          th_next.geothermal_cooldown =
            8'(step({8'h00, thresholds.geothermal_cooldown}, MAX8, th_cmd.up));
        thermo_pkg::TH_GEO_HEAT:
          th_next.geothermal_heatup =
            8'(step({8'h00, thresholds.geothermal_heatup}, MAX8, th_cmd.up));
        default: th_next = thresholds;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      thresholds <= thermo_pkg::RESET_THRESHOLDS;
    end else begin
      thresholds <= th_next;
    end
  end

endmodule

/* logic/uart_controller.sv */
`timescale 1ns/1ps

module uart_controller #(
  parameter int CLKS_PER_TICK = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rx,
  output thermo_pkg::thresholds_t thresholds,
  output logic                    tx
);

  logic                   tick;
  uart_pkg::byte_stream_t rx_byte;
  thermo_pkg::th_cmd_t    th_cmd;
  logic                   tx_valid;
  logic [7:0]             tx_data;
  logic                   tx_ready;

  // shared time base for both directions.
  baud_timer #(
    .CLKS_PER_TICK(CLKS_PER_TICK)
  ) u_baud_timer (
    .clk  (clk),
    .reset(reset),
    .tick (tick)
  );

  uart_rx u_uart_rx (
    .clk    (clk),
    .reset  (reset),
    .tick   (tick),
    .rx     (rx),
    .rx_byte(rx_byte)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .reset   (reset),
    .tick    (tick),
    .tx_valid(tx_valid),
    .tx_data (tx_data),
    .tx_ready(tx_ready),
    .tx      (tx)
  );

  command_fsm u_command_fsm (
    .clk       (clk),
    .reset     (reset),
    .rx_byte   (rx_byte),
    .thresholds(thresholds),
    .th_cmd    (th_cmd),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_ready  (tx_ready)
  );

  threshold_bank u_threshold_bank (
    .clk       (clk),
    .reset     (reset),
    .th_cmd    (th_cmd),
    .thresholds(thresholds)
  );

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // free-running, starts low.
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

endmodule

/* dv/tb_uart_model.svh */
// start bit and data bits, each one full bit time.
// returns as the stop bit begins, the line then stays high.
task automatic send_byte(input logic [7:0] data);
  logic [8:0] frame;
  frame = {data, 1'b0};
  for (int i = 0; i < 9; i++) begin
    @(posedge clk);
    #1;
    rx = frame[i];
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  end
  @(posedge clk);
  #1;
  rx = 1'b1;
endtask

// waits for a start bit on tx, then samples each bit at its middle.
task automatic recv_byte(input int timeout_clks, output logic [7:0] data, output bit got);
  int waited;
  got = 1'b0;
  data = 8'h00;
  waited = 0;
  while (tx && waited < timeout_clks) begin
    @(negedge clk);
    waited++;
  end
  if (tx) begin
    $display("timeout: no echo byte appeared on tx within %0d clocks (at %0t ns)",
             timeout_clks, $time);
  end else begin
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    if (tx) begin
      $display("start bit on tx ended before mid-bit (at %0t ns)", $time);
    end else begin
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (!tx) begin
        $display("stop bit on tx was low (at %0t ns)", $time);
      end else begin
        got = 1'b1;
      end
      repeat (CLKS_PER_BIT / 4) @(negedge clk);
    end
  end
endtask

/* dv/uart_controller_tb.sv */
`timescale 1ns/1ps

module uart_controller_tb;

  localparam int CLKS_PER_TICK = 4;
  localparam int CLKS_PER_BIT  = CLKS_PER_TICK * uart_pkg::OVERSAMPLE;
  localparam int FRAME_CLKS    = CLKS_PER_BIT * (uart_pkg::DATA_BITS + 2);

  logic                    clk;
  logic                    reset;
  logic                    rx;
  logic                    tx;
  thermo_pkg::thresholds_t thresholds;

  // reference model state, indexed by threshold id 1 to 9.
  int                 model_val [1:9];
  thermo_pkg::th_id_e model_sel;
  logic [15:0]        lfsr;
  int                 checks;
  int                 errors;
  int                 test_start;

  clock_gen #(.PERIOD_NS(40)) u_clock_gen (.clk(clk));

  uart_controller #(
    .CLKS_PER_TICK(CLKS_PER_TICK)
  ) u_uart_controller (
    .clk       (clk),
    .reset     (reset),
    .rx        (rx),
    .thresholds(thresholds),
    .tx        (tx)
  );

  `include "tb_uart_model.svh"

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hb400;
    end
    return next;
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic thermo_pkg::th_id_e letter_id(input logic [7:0] b);
    case (b)
      8'h41:   return thermo_pkg::TH_SOLAR;
      8'h42:   return thermo_pkg::TH_SOLAR_COOL;
      8'h43:   return thermo_pkg::TH_SOLAR_HEAT;
      8'h44:   return thermo_pkg::TH_GREEN_COOL;
      8'h45:   return thermo_pkg::TH_GREEN_HEAT;
      8'h46:   return thermo_pkg::TH_AMB_COOL;
      8'h47:   return thermo_pkg::TH_AMB_HEAT;
      8'h48:   return thermo_pkg::TH_GEO_COOL;
      8'h49:   return thermo_pkg::TH_GEO_HEAT;
      default: return thermo_pkg::TH_NONE;
    endcase
  endfunction

  function automatic void model_reset();
    model_val[1] = 1000;
    // even ids are cooldowns, odd ids heatups.
    for (int i = 2; i <= 9; i++) begin
      model_val[i] = (i % 2 == 0) ? 40 : 30;
    end
    model_sel = thermo_pkg::TH_NONE;
  endfunction

  function automatic thermo_pkg::thresholds_t model_pack();
    thermo_pkg::thresholds_t t;
    t.solar               = 16'(model_val[1]);
    t.solar_cooldown      = 8'(model_val[2]);
    t.solar_heatup        = 8'(model_val[3]);
    t.greenhouse_cooldown = 8'(model_val[4]);
    t.greenhouse_heatup   = 8'(model_val[5]);
    t.ambient_cooldown    = 8'(model_val[6]);
    t.ambient_heatup      = 8'(model_val[7]);
    t.geothermal_cooldown = 8'(model_val[8]);
    t.geothermal_heatup   = 8'(model_val[9]);
    return t;
  endfunction

  // expected echo value and echo byte count, zero when the byte is ignored.
  function automatic int model_apply(input logic [7:0] b, output logic [15:0] value);
    thermo_pkg::th_id_e id;
    int                 limit;
    id = letter_id(b);
    value = 16'h0000;
    if (id != thermo_pkg::TH_NONE) begin
      model_sel = id;
    end else if (model_sel == thermo_pkg::TH_NONE) begin
      return 0;
    end else if (b == 8'h77) begin
      limit = (model_sel == thermo_pkg::TH_SOLAR) ? 65535 : 255;
      if (model_val[int'(model_sel)] < limit) begin
        model_val[int'(model_sel)]++;
      end
    end else if (b == 8'h73) begin
      if (model_val[int'(model_sel)] > 0) begin
        model_val[int'(model_sel)]--;
      end
    end else begin
      return 0;
    end
    value = 16'(model_val[int'(model_sel)]);
    return (model_sel == thermo_pkg::TH_SOLAR) ? 2 : 1;
  endfunction

  // nine letters, 'w', 's' and '?'.
  function automatic logic [7:0] random_command(input int idx);
    if (idx < 9) begin
      return 8'h41 + 8'(idx);
    end else if (idx == 9) begin
      return 8'h77;
    end else if (idx == 10) begin
      return 8'h73;
    end
    return 8'h3f;
  endfunction

  task automatic check_thresholds(input thermo_pkg::thresholds_t got,
                                  input thermo_pkg::thresholds_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, thresholds %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_echo(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s, echo %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_no_echo(input string what);
    for (int i = 0; i < 2 * FRAME_CLKS; i++) begin
      @(negedge clk);
      if (!tx) begin
        errors++;
        $display("unexpected byte on tx %s (at %0t ns)", what, $time);
        repeat (FRAME_CLKS) @(negedge clk);
        break;
      end
    end
  endtask

  task automatic apply_command(input logic [7:0] b, output logic [7:0] first,
                               output logic [7:0] last);
    logic [15:0] value;
    logic [7:0]  data;
    int          count;
    bit          got;
    count = model_apply(b, value);
    first = 8'h00;
    last = 8'h00;
    send_byte(b);
    if (count == 0) begin
      expect_no_echo($sformatf("after ignored byte %h", b));
    end else begin
      for (int i = 0; i < count; i++) begin
        recv_byte(2 * FRAME_CLKS, data, got);
        if (!got) begin
          errors++;
          break;
        end
        if (i == 0) begin
          first = data;
        end
        last = data;
        check_echo(data, (count == 2 && i == 0) ? value[15:8] : value[7:0],
                   $sformatf("echo %0d of byte %h", i, b));
      end
    end
    check_thresholds(thresholds, model_pack(), $sformatf("after byte %h", b));
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    logic [7:0] first;
    logic [7:0] last;
    int         pick;
    rx = 1'b1;
    checks = 0;
    errors = 0;
    lfsr = 16'd50;
    model_reset();
    apply_reset();

    test_start = errors;
    @(negedge clk);
    check_thresholds(thresholds, model_pack(), "after reset");
    expect_no_echo("after reset");
    report_test("reset state", test_start);

    test_start = errors;
    apply_command(8'h43, first, last);
    repeat (3) apply_command(8'h77, first, last);
    check_echo(last, 8'd33, "solar heatup after three raises");
    report_test("solar heatup raise", test_start);

    test_start = errors;
    apply_command(8'h41, first, last);
    apply_command(8'h73, first, last);
    check_echo(first, 8'h03, "solar high byte");
    check_echo(last, 8'he7, "solar low byte");
    report_test("solar lower", test_start);

    test_start = errors;
    apply_command(8'h47, first, last);
    repeat (31) apply_command(8'h73, first, last);
    check_echo(last, 8'd0, "ambient heatup floor");
    apply_command(8'h48, first, last);
    repeat (216) apply_command(8'h77, first, last);
    check_echo(last, 8'd255, "geothermal cooldown ceiling");
    report_test("saturation", test_start);

    // fresh reset so that nothing is selected.
    test_start = errors;
    @(posedge clk);
    #1;
    apply_reset();
    model_reset();
    apply_command(8'h77, first, last);
    apply_command(8'h78, first, last);
    apply_command(8'h31, first, last);
    report_test("ignored bytes", test_start);

    test_start = errors;
    repeat (40) begin
      take_bits(4, pick);
      apply_command(random_command(pick % 12), first, last);
    end
    report_test("random commands", test_start);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+dv
logic/uart_pkg.sv
logic/thermo_pkg.sv
logic/baud_timer.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/command_fsm.sv
logic/threshold_bank.sv
logic/uart_controller.sv
dv/clock_gen.sv
dv/uart_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f \
  --top-module uart_controller_tb -o uart_controller_sim > build.log 2>&1 \
  && ./obj_dir/uart_controller_sim > sim.log 2>&1
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
